// ==== include/core_mem_front_cfg.svh ====
// memory front end configuration: widths, bus codes, sizes, reset pc, tags
`ifndef CORE_MEM_FRONT_CFG_SVH
`define CORE_MEM_FRONT_CFG_SVH

// datapath widths
`define XLEN          32
`define BLOCK_BITS    64
`define MEM_TAG_BITS  4
`define BUS_CMD_BITS  2
`define MEM_SIZE_BITS 2

// bus commands
`define BUS_NONE      2'b00
`define BUS_LOAD      2'b01
`define BUS_STORE     2'b10

// access sizes
`define SIZE_BYTE     2'b00
`define SIZE_HALF     2'b01
`define SIZE_WORD     2'b10
`define SIZE_DOUBLE   2'b11

// fetch sequencing
`define RESET_PC      32'h0000_0000
`define INST_BYTES    4

// tag zero means no transaction on the bus
`define MEM_TAG_NONE  4'h0

`endif

// ==== hw/core_mem_front_pkg.sv ====
// shared types for the fetch stage and the memory port arbiter
`default_nettype none

`include "core_mem_front_cfg.svh"

package core_mem_front_pkg;

    //////////////////////////////////////////////////////////////////////
    // plain vectors with a meaning
    //////////////////////////////////////////////////////////////////////

    // byte address
    typedef logic [`XLEN-1:0]          addr_t;
    // one instruction word
    typedef logic [`XLEN-1:0]          inst_t;
    // one memory block, two words
    typedef logic [`BLOCK_BITS-1:0]    block_t;
    // memory transaction tag, zero is idle
    typedef logic [`MEM_TAG_BITS-1:0]  mem_tag_t;
    typedef logic [`BUS_CMD_BITS-1:0]  bus_cmd_t;
    typedef logic [`MEM_SIZE_BITS-1:0] mem_size_t;

    //////////////////////////////////////////////////////////////////////
    // grouped signals
    //////////////////////////////////////////////////////////////////////

    // one memory bus request, data side or arbitrated bus
    typedef struct packed {
        bus_cmd_t  command;
        addr_t     addr;
        block_t    data;
        mem_size_t size;
    } mem_req_t;

    // fetched instruction waiting for dispatch
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t npc;
        inst_t inst;
    } if_id_packet_t;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
// fetch stage: pc, outstanding fetch tag, halt latch and the IF/ID register
`timescale 1ns/1ps
`default_nettype none

`include "core_mem_front_cfg.svh"

module fetch_stage
    import core_mem_front_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire logic     dispatch_ok,
    input  wire logic     halt,
    input  wire logic     redirect,
    input  wire addr_t    redirect_target,
    input  wire mem_tag_t imem_response,
    input  wire logic     fetch_stall,
    input  wire block_t   mem_data,
    input  wire mem_tag_t mem_tag,
    output addr_t         fetch_addr,
    output if_id_packet_t if_id,
    output logic          halted
);

    addr_t    pc;
    addr_t    pc_next;
    mem_tag_t pending_tag;
    inst_t    fetch_word;
    logic     if_id_take;
    logic     slot_free;
    logic     fetch_issue;
    logic     fetch_return;

    //////////////////////////////////////////////////////////////////////
    // fetch request and returned word
    //////////////////////////////////////////////////////////////////////

    // memory works in blocks, drop the offset bits
    assign fetch_addr = {pc[`XLEN-1:3], 3'b000};
    assign pc_next    = pc + addr_t'(`INST_BYTES);

    // pc bit 2 picks the half of the block
    assign fetch_word = pc[2] ? mem_data[`BLOCK_BITS-1:`XLEN] : mem_data[`XLEN-1:0];

    // entry leaves toward dispatch this edge
    assign if_id_take = if_id.valid && dispatch_ok;
    // room for the next return
    assign slot_free  = !if_id.valid || dispatch_ok;

    // memory took our load and nothing else blocks it
    assign fetch_issue = (imem_response != `MEM_TAG_NONE) && !halted && !fetch_stall &&
                         (pending_tag == `MEM_TAG_NONE) && slot_free;

    // return for the load still in flight
    assign fetch_return = (pending_tag != `MEM_TAG_NONE) && (mem_tag == pending_tag);

    //////////////////////////////////////////////////////////////////////
    // pc, pending tag, halt latch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc          <= `RESET_PC;
            pending_tag <= `MEM_TAG_NONE;
            halted      <= 1'b0;
        end else begin
            // sticky until reset
            if (halt) begin
                halted <= 1'b1;
            end
            if (redirect) begin
                // late data for the dropped tag no longer matches
                pc          <= redirect_target;
                pending_tag <= `MEM_TAG_NONE;
            end else if (halt) begin
                pending_tag <= `MEM_TAG_NONE;
            end else if (fetch_return) begin
                pc          <= pc_next;
                pending_tag <= `MEM_TAG_NONE;
            end else if (fetch_issue) begin
                pending_tag <= imem_response;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // IF/ID register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            if_id <= '0;
        end else if (redirect || halt) begin
            // flush
            if_id <= '0;
        end else if (fetch_return) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.npc   <= pc_next;
            if_id.inst  <= fetch_word;
        end else if (if_id_take) begin
            if_id.valid <= 1'b0;
        end
    end

    // a recorded tag only goes away, never swapped for another
    assert property (@(posedge clock) disable iff (reset)
        (pending_tag != `MEM_TAG_NONE) |=>
            (pending_tag == $past(pending_tag)) || (pending_tag == `MEM_TAG_NONE))
        else $error("fetch_stage: new tag recorded while fetch pending");

    // stalled entry holds until dispatch or a flush
    assert property (@(posedge clock) disable iff (reset)
        (if_id.valid && !dispatch_ok && !redirect && !halt) |=> $stable(if_id))
        else $error("fetch_stage: if_id changed under back-pressure");

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
// memory port arbiter: data side over fetch, request mux and response steering
`timescale 1ns/1ps
`default_nettype none

`include "core_mem_front_cfg.svh"

module mem_arbiter
    import core_mem_front_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire mem_req_t data_req,
    input  wire addr_t    fetch_addr,
    input  wire mem_tag_t mem_response,
    output mem_req_t      bus_req,
    output mem_tag_t      imem_response,
    output mem_tag_t      dmem_response,
    output logic          fetch_stall
);

    // data side owns the bus this cycle
    logic data_owner;
    // fetch_stall one falling edge later
    logic settle_q;

    //////////////////////////////////////////////////////////////////////
    // ownership
    //////////////////////////////////////////////////////////////////////

    // registered so the bus follows data_req one cycle late
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_owner <= 1'b0;
        end else begin
            data_owner <= (data_req.command != `BUS_NONE);
        end
    end

    // two falling-edge copies
    // responses only pass once both agree on the owner
    always_ff @(negedge clock or posedge reset) begin
        if (reset) begin
            fetch_stall <= 1'b0;
            settle_q    <= 1'b0;
        end else begin
            fetch_stall <= data_owner;
            settle_q    <= fetch_stall;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // request mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (data_owner) begin
            bus_req = data_req;
        end else begin
            // fetch always reads a whole block
            bus_req.command = `BUS_LOAD;
            bus_req.addr    = fetch_addr;
            bus_req.data    = '0;
            bus_req.size    = `SIZE_DOUBLE;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response steering
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        imem_response = `MEM_TAG_NONE;
        dmem_response = `MEM_TAG_NONE;
        if (fetch_stall && settle_q) begin
            // settled on data
            dmem_response = mem_response;
        end else if (!fetch_stall && !settle_q) begin
            // settled on fetch
            imem_response = mem_response;
        end
        // nobody sees the tag while the owner changes
    end

    // a tag only reaches the side that held the bus over both settle edges
    // so it never reaches both sides at once
    assert property (@(posedge clock) disable iff (reset)
        (dmem_response != `MEM_TAG_NONE) |-> (data_owner && $past(data_owner)))
        else $error("mem_arbiter: data response without settled data ownership");

    assert property (@(posedge clock) disable iff (reset)
        (imem_response != `MEM_TAG_NONE) |-> (!data_owner && !$past(data_owner)))
        else $error("mem_arbiter: fetch response without settled fetch ownership");

endmodule

`default_nettype wire

// ==== hw/core_mem_front.sv ====
// memory front end top: fetch stage feeding the shared memory port arbiter
`timescale 1ns/1ps
`default_nettype none

module core_mem_front
    import core_mem_front_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    // data side request, level
    input  wire mem_req_t data_req,
    // memory bus
    input  wire mem_tag_t mem_response,
    input  wire block_t   mem_data,
    input  wire mem_tag_t mem_tag,
    // downstream control
    input  wire logic     dispatch_ok,
    input  wire logic     halt,
    input  wire logic     redirect,
    input  wire addr_t    redirect_target,
    output mem_req_t      bus_req,
    output if_id_packet_t if_id,
    output mem_tag_t      dmem_response,
    output logic          halted
);

    // block-aligned fetch address
    addr_t    fetch_addr;
    // fetch side of the steered response
    mem_tag_t imem_response;
    // data side holds the bus
    logic     fetch_stall;

    //////////////////////////////////////////////////////////////////////
    // fetch
    //////////////////////////////////////////////////////////////////////

    fetch_stage fetch_stage_inst (
        .clock           (clock),
        .reset           (reset),
        .dispatch_ok     (dispatch_ok),
        .halt            (halt),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .imem_response   (imem_response),
        .fetch_stall     (fetch_stall),
        .mem_data        (mem_data),
        .mem_tag         (mem_tag),
        .fetch_addr      (fetch_addr),
        .if_id           (if_id),
        .halted          (halted)
    );

    //////////////////////////////////////////////////////////////////////
    // memory port
    //////////////////////////////////////////////////////////////////////

    mem_arbiter mem_arbiter_inst (
        .clock         (clock),
        .reset         (reset),
        .data_req      (data_req),
        .fetch_addr    (fetch_addr),
        .mem_response  (mem_response),
        .bus_req       (bus_req),
        .imem_response (imem_response),
        .dmem_response (dmem_response),
        .fetch_stall   (fetch_stall)
    );

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
// testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/mem_front_checker.sv ====
// checker: reference fetch order, bus mux and response steering, error counts
`timescale 1ns/1ps
`default_nettype none

`include "core_mem_front_cfg.svh"

module mem_front_checker
    import core_mem_front_pkg::*;
(
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire mem_req_t      data_req,
    input  wire mem_req_t      bus_req,
    input  wire if_id_packet_t if_id,
    input  wire mem_tag_t      mem_response,
    input  wire mem_tag_t      imem_response,
    input  wire mem_tag_t      dmem_response,
    input  wire logic          fetch_stall,
    input  wire logic          halted,
    input  wire logic          dispatch_ok,
    input  wire logic          halt,
    input  wire logic          redirect,
    input  wire addr_t         redirect_target,
    output int                 consumed_count,
    output int                 check_count,
    output int                 error_count
);

    // pc expected on the next dispatched entry
    addr_t         exp_pc;
    // data side activity per sample, newest in bit 0
    logic [1:0]    owner_hist;
    // entry stalled at the previous sample
    logic          hold_q;
    if_id_packet_t if_id_q;
    logic          halt_seen;
    // fetch pc frozen by the halt
    addr_t         halt_pc;
    logic          first_sample;
    addr_t         fetch_pc;
    mem_req_t      exp_bus;

    // memory image rule
    function automatic inst_t ref_word(input addr_t a);
        return (a ^ 32'h1e4b_0000) + (a * 32'd3);
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %s got %0h expected %0h at %0t ns", name, got, exp, $time);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // per-cycle compare on pre-edge values
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            exp_pc         = `RESET_PC;
            owner_hist     = 2'b00;
            hold_q         = 1'b0;
            if_id_q        = '0;
            halt_seen      = 1'b0;
            halt_pc        = `RESET_PC;
            first_sample   = 1'b1;
            consumed_count = 0;
            check_count    = 0;
            error_count    = 0;
        end else begin
            // empty slot out of reset and after halt
            if (first_sample || halt_seen) begin
                check_value("if_id.valid", 128'(if_id.valid), 128'(1'b0));
            end
            first_sample = 1'b0;
            check_value("halted", 128'(halted), 128'(halt_seen));

            // settle flags trail the owner by one and two falling edges
            check_value("fetch_stall", 128'(fetch_stall), 128'(owner_hist[0]));
            check_value("dmem_response", 128'(dmem_response),
                        128'((owner_hist == 2'b11) ? mem_response : `MEM_TAG_NONE));
            check_value("imem_response", 128'(imem_response),
                        128'((owner_hist == 2'b00) ? mem_response : `MEM_TAG_NONE));

            // next fetch pc, frozen once halted
            if (halt_seen) begin
                fetch_pc = halt_pc;
            end else begin
                fetch_pc = if_id.valid ? if_id.pc + 32'd4 : exp_pc;
            end

            // bus follows data_req one cycle late or carries the fetch load
            if (owner_hist[0]) begin
                exp_bus = data_req;
            end else begin
                exp_bus.command = `BUS_LOAD;
                exp_bus.addr    = {fetch_pc[`XLEN-1:3], 3'b000};
                exp_bus.data    = '0;
                exp_bus.size    = `SIZE_DOUBLE;
            end
            check_value("bus_req", 128'(bus_req), 128'(exp_bus));

            // stalled entry unchanged
            if (hold_q) begin
                check_value("if_id", 128'(if_id), 128'(if_id_q));
            end

            // dispatch in program order
            if (if_id.valid && dispatch_ok && !redirect && !halt) begin
                check_value("if_id.pc", 128'(if_id.pc), 128'(exp_pc));
                check_value("if_id.npc", 128'(if_id.npc), 128'(exp_pc + 32'd4));
                check_value("if_id.inst", 128'(if_id.inst), 128'(ref_word(exp_pc)));
                exp_pc = exp_pc + 32'd4;
                consumed_count++;
            end
            if (redirect) begin
                exp_pc = redirect_target;
            end
            if (halt) begin
                // pc stays where the halt caught it
                halt_pc   = fetch_pc;
                halt_seen = 1'b1;
            end

            hold_q     = if_id.valid && !dispatch_ok && !redirect && !halt;
            if_id_q    = if_id;
            owner_hist = {owner_hist[0], data_req.command != `BUS_NONE};
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_core_mem_front.sv ====
// testbench top: DUT, memory model, stimulus phases, watchdog and verdict
`timescale 1ns/1ps
`default_nettype none

`include "core_mem_front_cfg.svh"

module tb_core_mem_front
    import core_mem_front_pkg::*;
();

    localparam int CLOCK_PERIOD_NS = 20;
    localparam int TEST_INSTS      = 200;
    localparam int CYCLES_PER_INST = 20;

    logic          clock;
    logic          reset;
    mem_req_t      data_req;
    mem_tag_t      mem_response;
    block_t        mem_data;
    mem_tag_t      mem_tag;
    logic          dispatch_ok;
    logic          halt;
    logic          redirect;
    addr_t         redirect_target;
    mem_req_t      bus_req;
    if_id_packet_t if_id;
    mem_tag_t      dmem_response;
    logic          halted;
    int            consumed_count;
    int            check_count;
    int            error_count;

    // memory model state
    int            cycle_count;
    mem_tag_t      next_tag;
    int            ret_due[$];
    mem_tag_t      ret_tag[$];
    addr_t         ret_addr[$];
    // stimulus mode
    int unsigned   dispatch_pct;
    logic          bursts_on;
    int            burst_left;
    int unsigned   seed_draw;

    clock_gen #(.PERIOD_NS(CLOCK_PERIOD_NS), .RESET_CYCLES(2)) clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    core_mem_front core_mem_front_inst (
        .clock           (clock),
        .reset           (reset),
        .data_req        (data_req),
        .mem_response    (mem_response),
        .mem_data        (mem_data),
        .mem_tag         (mem_tag),
        .dispatch_ok     (dispatch_ok),
        .halt            (halt),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .bus_req         (bus_req),
        .if_id           (if_id),
        .dmem_response   (dmem_response),
        .halted          (halted)
    );

    mem_front_checker mem_front_checker_inst (
        .clock           (clock),
        .reset           (reset),
        .data_req        (data_req),
        .bus_req         (bus_req),
        .if_id           (if_id),
        .mem_response    (mem_response),
        .imem_response   (core_mem_front_inst.imem_response),
        .dmem_response   (dmem_response),
        .fetch_stall     (core_mem_front_inst.fetch_stall),
        .halted          (halted),
        .dispatch_ok     (dispatch_ok),
        .halt            (halt),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .consumed_count  (consumed_count),
        .check_count     (check_count),
        .error_count     (error_count)
    );

    //////////////////////////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////////////////////////

    function automatic inst_t memory_word(input addr_t a);
        return (a ^ 32'h1e4b_0000) + (a * 32'd3);
    endfunction

    // one return per cycle, then accept whatever the bus holds now
    task automatic serve_memory();
        int    due;
        addr_t base;
        cycle_count++;
        if (ret_due.size() > 0 && ret_due[0] <= cycle_count) begin
            base     = ret_addr[0] & ~32'h7;
            mem_tag  = ret_tag[0];
            mem_data = {memory_word(base + 32'd4), memory_word(base)};
            ret_due.delete(0);
            ret_tag.delete(0);
            ret_addr.delete(0);
        end else begin
            mem_tag  = `MEM_TAG_NONE;
            mem_data = '0;
        end
        if (bus_req.command != `BUS_NONE) begin
            mem_response = next_tag;
            if (bus_req.command == `BUS_LOAD) begin
                due = cycle_count + $urandom_range(5, 2);
                // keep returns in order, one slot each
                if (ret_due.size() > 0 && due <= ret_due[$]) begin
                    due = ret_due[$] + 1;
                end
                ret_due.push_back(due);
                ret_tag.push_back(next_tag);
                ret_addr.push_back(bus_req.addr);
            end
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end else begin
            mem_response = `MEM_TAG_NONE;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive_data_side();
        if (burst_left > 0) begin
            data_req.command = ($urandom_range(1, 0) != 0) ? `BUS_STORE : `BUS_LOAD;
            data_req.addr    = $urandom;
            data_req.data    = {$urandom, $urandom};
            data_req.size    = mem_size_t'($urandom_range(3, 0));
            burst_left--;
        end else begin
            data_req = '0;
            if (bursts_on && $urandom_range(7, 0) == 0) begin
                burst_left = $urandom_range(6, 1);
            end
        end
    endtask

    // memory reads bus_req before data_req moves
    task automatic step_cycle();
        @(negedge clock);
        serve_memory();
        drive_data_side();
        redirect    = 1'b0;
        halt        = 1'b0;
        dispatch_ok = ($urandom_range(99, 0) < dispatch_pct);
    endtask

    task automatic run_insts(input int count);
        int target;
        target = consumed_count + count;
        while (consumed_count < target) begin
            step_cycle();
        end
    endtask

    task automatic redirect_to(input addr_t target);
        repeat ($urandom_range(3, 0)) step_cycle();
        step_cycle();
        // nothing dispatched on the flush cycle
        dispatch_ok     = 1'b0;
        redirect        = 1'b1;
        redirect_target = target;
    endtask

    task automatic halt_fetch();
        step_cycle();
        dispatch_ok = 1'b0;
        halt        = 1'b1;
    endtask

    initial begin
        seed_draw       = $urandom(32'h1e4b);
        data_req        = '0;
        mem_response    = `MEM_TAG_NONE;
        mem_data        = '0;
        mem_tag         = `MEM_TAG_NONE;
        dispatch_ok     = 1'b0;
        halt            = 1'b0;
        redirect        = 1'b0;
        redirect_target = '0;
        cycle_count     = 0;
        next_tag        = 4'd1;
        dispatch_pct    = 100;
        bursts_on       = 1'b0;
        burst_left      = 0;
        @(negedge reset);

        // straight fetch, then random back-pressure, then data traffic
        run_insts(20);
        dispatch_pct = 50;
        run_insts(40);
        bursts_on    = 1'b1;
        dispatch_pct = 75;
        run_insts(60);

        // second target starts in the upper word of a block
        redirect_to($urandom & 32'h0000_fff8);
        run_insts(15);
        redirect_to(($urandom & 32'h0000_fff8) | 32'h4);
        run_insts(15);

        halt_fetch();
        repeat (20) step_cycle();
        bursts_on = 1'b0;
        repeat (4) step_cycle();

        $display("consumed %0d, checks %0d, errors %0d",
                 consumed_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // upper bound on the whole run
    initial begin
        #(TEST_INSTS * CYCLES_PER_INST * CLOCK_PERIOD_NS);
        $display("timeout: run did not finish, %0d entries dispatched, %0d errors",
                 consumed_count, error_count);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== core_mem_front.f ====
+incdir+include
hw/core_mem_front_pkg.sv
hw/fetch_stage.sv
hw/mem_arbiter.sv
hw/core_mem_front.sv
tb/clock_gen.sv
tb/mem_front_checker.sv
tb/tb_core_mem_front.sv

// ==== Makefile ====
# Verilator flow for the memory front end: lint, simulate, clean

VERILATOR ?= verilator
FILELIST  ?= core_mem_front.f
TB_TOP    ?= tb_core_mem_front
RTL_TOP   ?= core_mem_front
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
